/* list.f */
musicBoxPkg.sv
tickGenerator.sv
keyDebouncer.sv
toneSynth.sv
sampleFifo.sv
dacSerializer.sv
musicBoxTop.sv
tbMusicBox.sv

/* Makefile */
# Verilator build and run of the music box testbench
# A failing run ends in $fatal, so the simulator exit status is the result

VERILATOR ?= verilator
TOP       ?= tbMusicBox
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* tbMusicBox.sv */
/*
 * Music box testbench
 * Drives keys and enable switches, captures every DAC SPI frame
 * and checks its format and sample against a square-wave model
 */
`default_nettype none

module tbMusicBox;

	typedef enum {CHECK_SKIP, CHECK_ZERO, CHECK_TRACK} checkModeT;

	typedef struct packed {
		logic [7:0]            edges;  // Falling SCLK edges in the frame
		musicBoxPkg::dacFrameT frame;
	} capturedT;

	logic                 clock50Mhz = 1'b0;
	logic                 arstN      = 1'b0;
	musicBoxPkg::keyVecT  keys;
	musicBoxPkg::keyVecT  keyEnable;
	musicBoxPkg::dacPinsT dacPins;

	int          seed       = 32'h23dc;
	int unsigned cycleCount = 0;
	int unsigned cycleLimit = 3000000;  // Tests need about 2.2M
	int          halfLen [musicBoxPkg::NUM_KEYS] = '{61, 54, 48, 45, 40, 36};

	// Capture and model state
	logic [15:0]         shiftWord;
	int                  edgeCount;
	capturedT            frameQ [$];
	capturedT            curFrame;
	checkModeT           checkMode = CHECK_SKIP;
	musicBoxPkg::keyVecT heldKeys;
	musicBoxPkg::keyVecT phaseModel;
	int                  runCount [musicBoxPkg::NUM_KEYS];
	logic                synced = 1'b0;
	int                  framesSeen = 0;
	musicBoxPkg::audioSampleT expected;
	int                  keyA;
	int                  keyB;

	musicBoxTop i_musicBoxTop (
		.clock50Mhz (clock50Mhz),
		.arstN      (arstN),
		.keys       (keys),
		.keyEnable  (keyEnable),
		.dacPins    (dacPins)
	);

	always #20 clock50Mhz = ~clock50Mhz;

	// ------------------------------------------------
	// Helpers
	// ------------------------------------------------
	task automatic stopOnError(input string what);
		$display("%s", what);
		$display("test failed");
		$fatal(1, "simulation stopped on the first error");
	endtask

	// Expected sample for the given held keys and their phases
	function automatic musicBoxPkg::audioSampleT refSample(input musicBoxPkg::keyVecT active,
			input musicBoxPkg::keyVecT phaseHigh);
		int sum;
		sum = 0;
		for (int i = 0; i < musicBoxPkg::NUM_KEYS; i++) begin
			if (active[i] && phaseHigh[i])
				sum = sum + int'(musicBoxPkg::KEY_LEVEL);
		end
		return musicBoxPkg::audioSampleT'(sum << musicBoxPkg::MIX_SHIFT);
	endfunction

	task automatic driveInputs(input musicBoxPkg::keyVecT k, input musicBoxPkg::keyVecT en);
		@(posedge clock50Mhz);
		#5;
		keys      = k;
		keyEnable = en;
	endtask

	task automatic waitFrames(input int n);
		int target;
		target = framesSeen + n;
		wait (framesSeen >= target);
	endtask

	task automatic startTrack(input musicBoxPkg::keyVecT mask);
		driveInputs(mask, '1);
		heldKeys  = mask;
		synced    = 1'b0;
		checkMode = CHECK_TRACK;  // Zeros until the first tone sample
	endtask

	// ------------------------------------------------
	// SPI frame capture
	// ------------------------------------------------
	always @(negedge dacPins.syncN) begin
		shiftWord = '0;
		edgeCount = 0;
	end

	always @(negedge dacPins.sclk) begin
		if (!dacPins.syncN) begin
			shiftWord = {shiftWord[14:0], dacPins.din};  // MSB first
			edgeCount = edgeCount + 1;
		end
	end

	always @(posedge dacPins.syncN) begin
		if (arstN)
			frameQ.push_back({8'(edgeCount), shiftWord});
	end

	// ------------------------------------------------
	// Compare
	// ------------------------------------------------
	always @(posedge clock50Mhz) begin
		if (frameQ.size() > 0) begin
			curFrame = frameQ.pop_front();
			assert (curFrame.edges == 8'd16) else
				stopOnError($sformatf("[FAIL] %0t: frame had %0d SCLK edges", $time,
					curFrame.edges));
			assert (curFrame.frame.fields.powerDown == 2'b00) else
				stopOnError($sformatf("[FAIL] %0t: powerDown %b, expected 00", $time,
					curFrame.frame.fields.powerDown));
			if (checkMode == CHECK_ZERO) begin
				assert (curFrame.frame.fields.sample == '0) else
					stopOnError($sformatf("[FAIL] %0t: sample %0d, expected 0", $time,
						curFrame.frame.fields.sample));
			end else if (checkMode == CHECK_TRACK) begin
				if (!synced && curFrame.frame.fields.sample != '0) begin
					synced     = 1'b1;  // All phases high at the first tone sample
					phaseModel = '1;
					for (int i = 0; i < musicBoxPkg::NUM_KEYS; i++)
						runCount[i] = 0;
				end
				expected = synced ? refSample(heldKeys, phaseModel) : '0;
				assert (curFrame.frame.fields.sample == expected) else
					stopOnError($sformatf("[FAIL] %0t: sample %0d, expected %0d", $time,
						curFrame.frame.fields.sample, expected));
				if (synced) begin
					for (int i = 0; i < musicBoxPkg::NUM_KEYS; i++) begin
						if (heldKeys[i]) begin
							runCount[i] = runCount[i] + 1;
							if (runCount[i] == halfLen[i]) begin
								runCount[i]   = 0;
								phaseModel[i] = ~phaseModel[i];  // Half wave done
							end
						end
					end
				end
			end
			framesSeen = framesSeen + 1;
		end
	end

	// Run limit
	always @(posedge clock50Mhz) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= cycleLimit)
			stopOnError("Timeout: the run went past its cycle limit without finishing");
	end

	// ------------------------------------------------
	// Stimulus
	// ------------------------------------------------
	initial begin
		keys      = '0;
		keyEnable = '1;
		repeat (10) @(posedge clock50Mhz);
		#5;
		arstN = 1'b1;
		assert (dacPins.syncN && dacPins.sclk && !dacPins.din) else
			stopOnError($sformatf("[FAIL] %0t: SPI pins not idle after reset", $time));

		// Idle frames carry silence
		checkMode = CHECK_ZERO;
		waitFrames(20);

		// One random key
		keyA = {$random(seed)} % musicBoxPkg::NUM_KEYS;
		startTrack(musicBoxPkg::keyVecT'(1) << keyA);
		wait (synced);
		waitFrames(5 * halfLen[keyA]);
		driveInputs('0, '1);
		checkMode = CHECK_SKIP;  // Release goes through debounce
		waitFrames(340);

		// Two keys mixed
		keyA = {$random(seed)} % musicBoxPkg::NUM_KEYS;
		keyB = (keyA + 1 + {$random(seed)} % (musicBoxPkg::NUM_KEYS - 1)) % musicBoxPkg::NUM_KEYS;
		startTrack((musicBoxPkg::keyVecT'(1) << keyA) | (musicBoxPkg::keyVecT'(1) << keyB));
		wait (synced);
		waitFrames(300);
		driveInputs('0, '1);
		checkMode = CHECK_SKIP;
		waitFrames(340);

		// Pressed key with its switch off
		keyA      = {$random(seed)} % musicBoxPkg::NUM_KEYS;
		checkMode = CHECK_ZERO;
		driveInputs(musicBoxPkg::keyVecT'(1) << keyA, ~(musicBoxPkg::keyVecT'(1) << keyA));
		waitFrames(340);
		driveInputs('0, '1);

		// Pulse shorter than one debounce period
		keyA = {$random(seed)} % musicBoxPkg::NUM_KEYS;
		driveInputs(musicBoxPkg::keyVecT'(1) << keyA, '1);
		repeat (30000) @(posedge clock50Mhz);
		driveInputs('0, '1);
		waitFrames(340);

		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

/* musicBoxTop.sv */
/*
 * Music box audio path top level
 * Keys through debounce into the tone synthesizer, then the sample
 * FIFO and the DAC serializer out to the SPI pins
 */
`default_nettype none

module musicBoxTop (
	input  wire                      clock50Mhz,
	input  wire                      arstN,
	input  wire musicBoxPkg::keyVecT keys,
	input  wire musicBoxPkg::keyVecT keyEnable,
	output wire musicBoxPkg::dacPinsT dacPins
);

	// ------------------------------------------------
	// Interconnect
	// ------------------------------------------------
	wire logic                     sampleTick;
	wire logic                     debounceTick;
	wire musicBoxPkg::keyVecT      keysClean;
	wire logic                     synthValid;   // Synth to FIFO
	wire logic                     synthReady;
	wire musicBoxPkg::audioSampleT synthSample;
	wire logic                     fifoValid;    // FIFO to serializer
	wire logic                     fifoReady;
	wire musicBoxPkg::audioSampleT fifoSample;

	tickGenerator i_tickGenerator (
		.clock50Mhz   (clock50Mhz),
		.arstN        (arstN),
		.sampleTick   (sampleTick),
		.debounceTick (debounceTick)
	);

	keyDebouncer i_keyDebouncer (
		.clock50Mhz   (clock50Mhz),
		.arstN        (arstN),
		.debounceTick (debounceTick),
		.keys         (keys),
		.keyEnable    (keyEnable),
		.keysClean    (keysClean)
	);

	toneSynth i_toneSynth (
		.clock50Mhz  (clock50Mhz),
		.arstN       (arstN),
		.sampleTick  (sampleTick),
		.keysClean   (keysClean),
		.synthValid  (synthValid),
		.synthReady  (synthReady),
		.synthSample (synthSample)
	);

	sampleFifo i_sampleFifo (
		.clock50Mhz (clock50Mhz),
		.arstN      (arstN),
		.inValid    (synthValid),
		.inReady    (synthReady),
		.inSample   (synthSample),
		.outValid   (fifoValid),
		.outReady   (fifoReady),
		.outSample  (fifoSample)
	);

	dacSerializer i_dacSerializer (
		.clock50Mhz (clock50Mhz),
		.arstN      (arstN),
		.fifoValid  (fifoValid),
		.fifoReady  (fifoReady),
		.fifoSample (fifoSample),
		.dacPins    (dacPins)
	);

endmodule

`default_nettype wire

/* dacSerializer.sv */
/*
 * DAC serializer
 * Takes one sample at a time, wraps it in a 16-bit DAC frame and
 * shifts it out MSB first on SCLK, SYNC_n and DIN
 */
`default_nettype none

module dacSerializer (
	input  wire                          clock50Mhz,
	input  wire                          arstN,
	input  wire                          fifoValid,
	output logic                         fifoReady,
	input  wire musicBoxPkg::audioSampleT fifoSample,
	output musicBoxPkg::dacPinsT         dacPins
);

	musicBoxPkg::serStateT state;
	musicBoxPkg::spiCntT   phaseCount;  // SCLK half period or gap time
	musicBoxPkg::bitCntT   bitCount;    // Falling edges done minus one
	musicBoxPkg::dacFrameT frameIn;
	logic [musicBoxPkg::FRAME_BITS-1:0] shiftReg;  // Bits still to send at the top
	logic accept;
	logic riseEdge;

	assign fifoReady = (state == musicBoxPkg::SER_IDLE);
	assign accept    = fifoValid && fifoReady;
	assign riseEdge  = (state == musicBoxPkg::SER_SHIFT) && !dacPins.sclk
		&& (phaseCount == musicBoxPkg::SCLK_LAST);

	// Frame word from the incoming sample
	always_comb begin
		frameIn.fields.unused    = 2'b00;
		frameIn.fields.powerDown = musicBoxPkg::POWER_NORMAL;
		frameIn.fields.sample    = fifoSample;
	end

	// ------------------------------------------------
	// Frame FSM and SPI pins
	// ------------------------------------------------
	always_ff @(posedge clock50Mhz or negedge arstN) begin
		if (!arstN) begin
			state         <= musicBoxPkg::SER_IDLE;
			phaseCount    <= '0;
			bitCount      <= '0;
			dacPins.sclk  <= 1'b1;
			dacPins.syncN <= 1'b1;
			dacPins.din   <= 1'b0;
		end else begin
			case (state)
				musicBoxPkg::SER_IDLE: begin
					if (accept) begin
						state         <= musicBoxPkg::SER_SHIFT;
						phaseCount    <= '0;
						bitCount      <= '0;
						dacPins.syncN <= 1'b0;  // Frame starts next cycle
						dacPins.din   <= frameIn.raw[musicBoxPkg::FRAME_BITS-1];
					end
				end
				musicBoxPkg::SER_SHIFT: begin
					if (phaseCount == musicBoxPkg::SCLK_LAST) begin
						phaseCount <= '0;
						if (dacPins.sclk) begin
							dacPins.sclk <= 1'b0;  // DAC samples DIN here
						end else if (bitCount == musicBoxPkg::BIT_LAST) begin
							// Last bit taken, close the frame
							dacPins.sclk  <= 1'b1;
							dacPins.syncN <= 1'b1;
							dacPins.din   <= 1'b0;
							state         <= musicBoxPkg::SER_GAP;
						end else begin
							dacPins.sclk <= 1'b1;
							dacPins.din  <= shiftReg[musicBoxPkg::FRAME_BITS-1];  // Next bit
							bitCount     <= bitCount + 1'b1;
						end
					end else begin
						phaseCount <= phaseCount + 1'b1;
					end
				end
				musicBoxPkg::SER_GAP: begin
					// SYNC_n held high before the next frame
					if (phaseCount == musicBoxPkg::GAP_LAST) begin
						phaseCount <= '0;
						state      <= musicBoxPkg::SER_IDLE;
					end else begin
						phaseCount <= phaseCount + 1'b1;
					end
				end
				default: state <= musicBoxPkg::SER_IDLE;
			endcase
		end
	end

	// Shift register, MSB already on DIN at load
	always_ff @(posedge clock50Mhz) begin
		if (accept)
			shiftReg <= frameIn.raw << 1;
		else if (riseEdge)
			shiftReg <= shiftReg << 1;
	end

endmodule

`default_nettype wire

/* sampleFifo.sv */
/*
 * Sample FIFO
 * Four-entry circular buffer between the tone synthesizer and the
 * DAC serializer, valid/ready on both sides
 */
`default_nettype none

module sampleFifo (
	input  wire                          clock50Mhz,
	input  wire                          arstN,
	input  wire                          inValid,
	output logic                         inReady,
	input  wire musicBoxPkg::audioSampleT inSample,
	output logic                         outValid,
	input  wire                          outReady,
	output musicBoxPkg::audioSampleT     outSample
);

	musicBoxPkg::audioSampleT mem [musicBoxPkg::FIFO_DEPTH];
	musicBoxPkg::fifoPtrT     wrPtr;  // Wraps naturally, depth is a power of two
	musicBoxPkg::fifoPtrT     rdPtr;
	musicBoxPkg::fifoCntT     count;
	logic push;
	logic pop;

	assign inReady   = (count != musicBoxPkg::FIFO_FULL);  // Back-pressure when full
	assign outValid  = (count != '0);
	assign outSample = mem[rdPtr];  // Head entry

	assign push = inValid && inReady;
	assign pop  = outValid && outReady;

	// ------------------------------------------------
	// Pointers and fill count
	// ------------------------------------------------
	always_ff @(posedge clock50Mhz or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push)
				wrPtr <= wrPtr + 1'b1;
			if (pop)
				rdPtr <= rdPtr + 1'b1;

			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // Both or neither
			endcase
		end
	end

	// Storage
	always_ff @(posedge clock50Mhz) begin
		if (push)
			mem[wrPtr] <= inSample;
	end

endmodule

`default_nettype wire

/* toneSynth.sv */
/*
 * Tone synthesizer
 * Keeps a square-wave phase per key, mixes the held keys into one
 * 12-bit sample per sample tick and offers it on a valid/ready port
 */
`default_nettype none

module toneSynth (
	input  wire                      clock50Mhz,
	input  wire                      arstN,
	input  wire                      sampleTick,
	input  wire musicBoxPkg::keyVecT keysClean,
	output logic                     synthValid,
	input  wire                      synthReady,
	output musicBoxPkg::audioSampleT synthSample
);

	musicBoxPkg::keyVecT phase;    // High half of each square wave
	musicBoxPkg::keyVecT mixKeys;  // Keys mixed into the pending sample
	logic [musicBoxPkg::NUM_KEYS-1:0][7:0] halfCount;  // Samples into current half
	logic [7:0] mixSum;
	logic       transfer;
	logic       formSample;

	assign transfer   = synthValid && synthReady;
	assign formSample = sampleTick && !synthValid;  // Tick dropped while one is pending

	// ------------------------------------------------
	// Mixer
	// ------------------------------------------------
	// Six keys at full level stay below 256
	always_comb begin
		mixSum = '0;
		for (int i = 0; i < musicBoxPkg::NUM_KEYS; i++) begin
			if (keysClean[i] && phase[i])
				mixSum = mixSum + musicBoxPkg::KEY_LEVEL;
		end
	end

	// ------------------------------------------------
	// Handshake and phase tracking
	// ------------------------------------------------
	always_ff @(posedge clock50Mhz or negedge arstN) begin
		if (!arstN) begin
			synthValid <= 1'b0;
			mixKeys    <= '0;
			phase      <= '1;
			halfCount  <= '0;
		end else begin
			if (formSample) begin
				synthValid <= 1'b1;
				mixKeys    <= keysClean;
			end else if (transfer) begin
				synthValid <= 1'b0;
			end

			for (int i = 0; i < musicBoxPkg::NUM_KEYS; i++) begin
				if (!keysClean[i]) begin
					// Released key waits at the start of a high half
					phase[i]     <= 1'b1;
					halfCount[i] <= '0;
				end else if (transfer && mixKeys[i]) begin
					// Step only for samples that actually left
					if (halfCount[i] == musicBoxPkg::HALF_PERIOD[i] - 8'd1) begin
						halfCount[i] <= '0;
						phase[i]     <= ~phase[i];  // Half wave done
					end else begin
						halfCount[i] <= halfCount[i] + 8'd1;
					end
				end
			end
		end
	end

	// Sample word, held until it transfers
	always_ff @(posedge clock50Mhz) begin
		if (formSample)
			synthSample <= musicBoxPkg::audioSampleT'(mixSum) << musicBoxPkg::MIX_SHIFT;
	end

endmodule

`default_nettype wire

/* keyDebouncer.sv */
/*
 * Key debouncer
 * Gates each music key with its enable switch, synchronizes it and
 * only lets the clean level follow after several equal tick samples
 */
`default_nettype none

module keyDebouncer (
	input  wire                  clock50Mhz,
	input  wire                  arstN,
	input  wire                  debounceTick,
	input  wire musicBoxPkg::keyVecT keys,       // Active high
	input  wire musicBoxPkg::keyVecT keyEnable,  // Per-key enable switch
	output musicBoxPkg::keyVecT  keysClean
);

	musicBoxPkg::keyVecT keyMeta;  // First sync stage
	musicBoxPkg::keyVecT keySync;  // Safe to sample
	musicBoxPkg::agreeCntT [musicBoxPkg::NUM_KEYS-1:0] agreeCount;

	// ------------------------------------------------
	// Enable gating and input sync
	// ------------------------------------------------
	always_ff @(posedge clock50Mhz or negedge arstN) begin
		if (!arstN) begin
			keyMeta <= '0;
			keySync <= '0;
		end else begin
			keyMeta <= keys & keyEnable;  // Disabled key reads as released
			keySync <= keyMeta;
		end
	end

	// ------------------------------------------------
	// Per-key agreement counters
	// ------------------------------------------------
	always_ff @(posedge clock50Mhz or negedge arstN) begin
		if (!arstN) begin
			keysClean  <= '0;
			agreeCount <= '0;
		end else if (debounceTick) begin
			for (int i = 0; i < musicBoxPkg::NUM_KEYS; i++) begin
				if (keySync[i] == keysClean[i]) begin
					agreeCount[i] <= '0;  // Matches clean level, start over
				end else if (agreeCount[i] == musicBoxPkg::AGREE_LAST) begin
					keysClean[i]  <= keySync[i];
					agreeCount[i] <= '0;
				end else begin
					agreeCount[i] <= agreeCount[i] + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* tickGenerator.sv */
/*
 * Tick generator
 * Two free-running dividers on the 50 MHz clock giving one-cycle
 * enables for the sample rate and the key debounce
 */
`default_nettype none

module tickGenerator (
	input  wire  clock50Mhz,
	input  wire  arstN,
	output logic sampleTick,
	output logic debounceTick
);

	musicBoxPkg::sampleCntT   sampleCount;
	musicBoxPkg::debounceCntT debounceCount;

	// Pulse on the last count of each divider
	assign sampleTick   = (sampleCount == musicBoxPkg::SAMPLE_LAST);
	assign debounceTick = (debounceCount == musicBoxPkg::DEBOUNCE_LAST);

	always_ff @(posedge clock50Mhz or negedge arstN) begin
		if (!arstN) begin
			sampleCount   <= '0;
			debounceCount <= '0;
		end else begin
			if (sampleTick)
				sampleCount <= '0;  // Wrap
			else
				sampleCount <= sampleCount + 1'b1;

			if (debounceTick)
				debounceCount <= '0;
			else
				debounceCount <= debounceCount + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* musicBoxPkg.sv */
/*
 * Music box shared definitions
 * Key and sample types, DAC SPI pin bundle and frame layout,
 * plus every divider, count and tone constant of the audio path
 */
`default_nettype none

package musicBoxPkg;

	// ------------------------------------------------
	// Keys, ticks and tones
	// ------------------------------------------------
	localparam int NUM_KEYS       = 6;
	localparam int SAMPLE_DIV     = 781;    // Clocks per sample tick
	localparam int DEBOUNCE_DIV   = 50000;  // Clocks per 1 kHz debounce tick
	localparam int DEBOUNCE_TICKS = 4;      // Equal samples before a key flips
	localparam int MIX_SHIFT      = 3;      // 8-bit mix to 12-bit sample, times eight
	localparam int FIFO_DEPTH     = 4;
	localparam int SCLK_HALF      = 2;      // Clocks per SCLK half period
	localparam int SYNC_GAP       = 2;      // Minimum SYNC_n high time between frames

	localparam logic [7:0] KEY_LEVEL = 8'd40;
	// Samples per half wave, entry 0 is key 0
	localparam logic [NUM_KEYS-1:0][7:0] HALF_PERIOD =
		{8'd36, 8'd40, 8'd45, 8'd48, 8'd54, 8'd61};
	localparam logic [1:0] POWER_NORMAL = 2'b00;

	typedef logic [NUM_KEYS-1:0] keyVecT;
	typedef logic [11:0]         audioSampleT;

	// Counter widths
	typedef logic [$clog2(SAMPLE_DIV)-1:0]     sampleCntT;
	typedef logic [$clog2(DEBOUNCE_DIV)-1:0]   debounceCntT;
	typedef logic [$clog2(DEBOUNCE_TICKS)-1:0] agreeCntT;
	typedef logic [$clog2(FIFO_DEPTH)-1:0]     fifoPtrT;
	typedef logic [$clog2(FIFO_DEPTH):0]       fifoCntT;
	typedef logic [1:0]                        spiCntT;  // Covers SCLK half and gap

	localparam sampleCntT   SAMPLE_LAST   = sampleCntT'(SAMPLE_DIV - 1);
	localparam debounceCntT DEBOUNCE_LAST = debounceCntT'(DEBOUNCE_DIV - 1);
	localparam agreeCntT    AGREE_LAST    = agreeCntT'(DEBOUNCE_TICKS - 1);
	localparam fifoCntT     FIFO_FULL     = fifoCntT'(FIFO_DEPTH);
	localparam spiCntT      SCLK_LAST     = spiCntT'(SCLK_HALF - 1);
	localparam spiCntT      GAP_LAST      = spiCntT'(SYNC_GAP - 1);

	// ------------------------------------------------
	// DAC SPI interface
	// ------------------------------------------------
	typedef struct packed {
		logic sclk;   // Idles high
		logic syncN;  // Low for the whole frame
		logic din;    // Sampled by the DAC on falling SCLK
	} dacPinsT;

	typedef struct packed {
		logic [1:0]  unused;
		logic [1:0]  powerDown;  // 00 is normal operation
		audioSampleT sample;
	} dacFieldsT;

	// Built through fields, shifted out as raw MSB first
	typedef union packed {
		logic [15:0] raw;
		dacFieldsT   fields;
	} dacFrameT;

	localparam int FRAME_BITS = $bits(dacFrameT);
	typedef logic [$clog2(FRAME_BITS)-1:0] bitCntT;
	localparam bitCntT BIT_LAST = bitCntT'(FRAME_BITS - 1);

	typedef enum logic [1:0] {
		SER_IDLE,
		SER_SHIFT,
		SER_GAP
	} serStateT;

endpackage

`default_nettype wire
